// File: verilog/display_pkg.sv
package display_pkg;

	localparam int COORD_W = 11; // Same width as the raster counters

	// Horizontal timing in pixels
	localparam int DEF_H_ACTIVE = 16;
	localparam int DEF_H_FRONT  = 2;
	localparam int DEF_H_SYNC   = 4;
	localparam int DEF_H_BACK   = 2; // Total 24

	// Vertical timing in lines
	localparam int DEF_V_ACTIVE = 8;
	localparam int DEF_V_FRONT  = 1;
	localparam int DEF_V_SYNC   = 2;
	localparam int DEF_V_BACK   = 1; // Total 12

	localparam int DEF_TILE_SHIFT = 2; // 4x4 pixel tiles

	typedef logic [7:0] colour_t; // One colour channel

	// Frame memory word
	// Host side writes it raw, display side reads BGRA
	typedef union packed {
		logic [31:0] raw; // Host view
		struct packed {
			colour_t blue;  // Bits 31:24
			colour_t green; // Bits 23:16
			colour_t red;   // Bits 15:8
			colour_t alpha; // Bits 7:0, never shown
		} colour;
	} pixel_word_t;

endpackage

// File: verilog/scan_if.sv
`timescale 1ns/1ps

interface scan_if;
	import display_pkg::*;

	logic [COORD_W-1:0] x;  // Pixel position in line
	logic [COORD_W-1:0] y;  // Line position in frame
	logic               hs; // Active low
	logic               vs; // Active low
	logic               active; // Visible region

	// Timing generator side
	modport gen (
		output x, y, hs, vs, active
	);

	// Fetch stage side
	modport fetch (
		input x, y, hs, vs, active
	);

endinterface

// File: verilog/pixel_if.sv
`timescale 1ns/1ps

interface pixel_if;
	import display_pkg::*;

	pixel_word_t word;   // Tile word for this pixel
	logic        hs;     // Delayed to match word
	logic        vs;     // Delayed to match word
	logic        active; // Delayed to match word

	modport fetch (
		output word, hs, vs, active
	);

	modport out (
		input word, hs, vs, active
	);

endinterface

// File: verilog/vga_timing_generator.sv
`timescale 1ns/1ps

module vga_timing_generator #(
	parameter int H_ACTIVE = display_pkg::DEF_H_ACTIVE,
	parameter int H_FRONT  = display_pkg::DEF_H_FRONT,
	parameter int H_SYNC   = display_pkg::DEF_H_SYNC,
	parameter int H_BACK   = display_pkg::DEF_H_BACK,
	parameter int V_ACTIVE = display_pkg::DEF_V_ACTIVE,
	parameter int V_FRONT  = display_pkg::DEF_V_FRONT,
	parameter int V_SYNC   = display_pkg::DEF_V_SYNC,
	parameter int V_BACK   = display_pkg::DEF_V_BACK
) (
	input logic clk,
	input logic rst_n,
	scan_if.gen scan
);
	import display_pkg::*;

	localparam int H_TOTAL      = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
	localparam int V_TOTAL      = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
	localparam int H_SYNC_START = H_ACTIVE + H_FRONT; // First sync pixel
	localparam int H_SYNC_END   = H_SYNC_START + H_SYNC; // First pixel after sync
	localparam int V_SYNC_START = V_ACTIVE + V_FRONT;
	localparam int V_SYNC_END   = V_SYNC_START + V_SYNC;

	logic [COORD_W-1:0] x_next; // Position one clock ahead
	logic [COORD_W-1:0] y_next;
	logic               line_end;  // Last pixel of line
	logic               frame_end; // Last line of frame
	logic               hs_next;
	logic               vs_next;
	logic               active_next;

	// Counter advance
	always_comb
	begin
		line_end  = (scan.x == COORD_W'(H_TOTAL - 1));
		frame_end = (scan.y == COORD_W'(V_TOTAL - 1));
		x_next    = line_end ? '0 : scan.x + 1'b1; // Wrap at line end
		if (line_end)
			y_next = frame_end ? '0 : scan.y + 1'b1; // Next line or new frame
		else
			y_next = scan.y;
	end

	// Decode from next position so flags line up with x/y
	always_comb
	begin
		hs_next     = !((x_next >= H_SYNC_START) && (x_next < H_SYNC_END));
		vs_next     = !((y_next >= V_SYNC_START) && (y_next < V_SYNC_END));
		active_next = (x_next < H_ACTIVE) && (y_next < V_ACTIVE);
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			scan.x      <= '0;
			scan.y      <= '0;
			scan.hs     <= 1'b1; // Syncs idle high
			scan.vs     <= 1'b1;
			scan.active <= 1'b0;
		end
		else
		begin
			scan.x      <= x_next;
			scan.y      <= y_next;
			scan.hs     <= hs_next;
			scan.vs     <= vs_next;
			scan.active <= active_next;
		end
	end

endmodule

// File: verilog/frame_memory.sv
`timescale 1ns/1ps

module frame_memory #(
	parameter int DEPTH = (display_pkg::DEF_H_ACTIVE >> display_pkg::DEF_TILE_SHIFT)
		* (display_pkg::DEF_V_ACTIVE >> display_pkg::DEF_TILE_SHIFT)
) (
	input  logic                     clk,
	input  logic                     write,      // One-cycle host strobe
	input  logic [7:0]               write_addr, // Host word address
	input  display_pkg::pixel_word_t write_data,
	input  logic [7:0]               read_addr,  // Display tile address
	output display_pkg::pixel_word_t read_data
);
	import display_pkg::*;

	localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1; // Array index bits

	pixel_word_t mem [DEPTH]; // One word per tile
	logic        write_ok;

	assign write_ok = write && (write_addr < DEPTH); // Drop writes past the tile count

	// Read-first so a same-address read sees the old word
	always_ff @(posedge clk)
	begin
		if (write_ok)
			mem[write_addr[IDX_W-1:0]] <= write_data;
		read_data <= mem[read_addr[IDX_W-1:0]];
	end

endmodule

// File: verilog/tile_fetch.sv
`timescale 1ns/1ps

module tile_fetch #(
	parameter int H_ACTIVE   = display_pkg::DEF_H_ACTIVE,
	parameter int TILE_SHIFT = display_pkg::DEF_TILE_SHIFT
) (
	input  logic                     clk,
	input  logic                     rst_n,
	scan_if.fetch                    scan,
	output logic [7:0]               mem_addr, // To memory read port
	input  display_pkg::pixel_word_t mem_data, // One cycle after mem_addr
	pixel_if.fetch                   pix
);
	import display_pkg::*;

	localparam int TILES_X = H_ACTIVE >> TILE_SHIFT; // Tiles per row

	logic [COORD_W-1:0]   tile_col;
	logic [COORD_W-1:0]   tile_row;
	logic [2*COORD_W-1:0] tile_index; // Wide enough for any row times column

	// Position to tile index
	always_comb
	begin
		tile_col   = scan.x >> TILE_SHIFT;
		tile_row   = scan.y >> TILE_SHIFT;
		tile_index = tile_row * (2*COORD_W)'(TILES_X) + tile_col;
		// Park on tile 0 in blanking so reads stay in range
		mem_addr   = scan.active ? tile_index[7:0] : '0;
	end

	assign pix.word = mem_data; // Memory output is already registered

	// Controls delayed to meet the read data
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			pix.hs     <= 1'b1;
			pix.vs     <= 1'b1;
			pix.active <= 1'b0;
		end
		else
		begin
			pix.hs     <= scan.hs;
			pix.vs     <= scan.vs;
			pix.active <= scan.active;
		end
	end

endmodule

// File: verilog/pixel_output.sv
`timescale 1ns/1ps

module pixel_output (
	input  logic                 clk,
	input  logic                 rst_n,
	pixel_if.out                 pix,
	output logic                 vga_hs,
	output logic                 vga_vs,
	output logic                 vga_blank_n,
	output display_pkg::colour_t vga_r,
	output display_pkg::colour_t vga_g,
	output display_pkg::colour_t vga_b
);
	import display_pkg::*;

	colour_t red_next; // Blanked channel values
	colour_t green_next;
	colour_t blue_next;

	// BGRA unpack, alpha dropped
	always_comb
	begin
		red_next   = pix.active ? pix.word.colour.red : '0;
		green_next = pix.active ? pix.word.colour.green : '0;
		blue_next  = pix.active ? pix.word.colour.blue : '0; // Black outside active area
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			vga_hs      <= 1'b1;
			vga_vs      <= 1'b1;
			vga_blank_n <= 1'b0;
			vga_r       <= '0;
			vga_g       <= '0;
			vga_b       <= '0;
		end
		else
		begin
			vga_hs      <= pix.hs;
			vga_vs      <= pix.vs;
			vga_blank_n <= pix.active; // Blank is the inverse of active
			vga_r       <= red_next;
			vga_g       <= green_next;
			vga_b       <= blue_next;
		end
	end

endmodule

// File: verilog/display_top.sv
`timescale 1ns/1ps

module display_top #(
	parameter int H_ACTIVE   = display_pkg::DEF_H_ACTIVE,
	parameter int H_FRONT    = display_pkg::DEF_H_FRONT,
	parameter int H_SYNC     = display_pkg::DEF_H_SYNC,
	parameter int H_BACK     = display_pkg::DEF_H_BACK,
	parameter int V_ACTIVE   = display_pkg::DEF_V_ACTIVE,
	parameter int V_FRONT    = display_pkg::DEF_V_FRONT,
	parameter int V_SYNC     = display_pkg::DEF_V_SYNC,
	parameter int V_BACK     = display_pkg::DEF_V_BACK,
	parameter int TILE_SHIFT = display_pkg::DEF_TILE_SHIFT
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 fb_write, // Host write strobe
	input  logic [7:0]           fb_addr,
	input  logic [31:0]          fb_data,
	output logic                 vga_hs,
	output logic                 vga_vs,
	output logic                 vga_blank_n,
	output display_pkg::colour_t vga_r,
	output display_pkg::colour_t vga_g,
	output display_pkg::colour_t vga_b
);
	import display_pkg::*;

	localparam int DEPTH = (H_ACTIVE >> TILE_SHIFT) * (V_ACTIVE >> TILE_SHIFT); // Tile count

	scan_if  scan ();
	pixel_if pix ();

	logic [7:0]  read_addr; // Fetch to memory
	pixel_word_t read_data;
	pixel_word_t host_word;

	assign host_word.raw = fb_data; // Host writes the raw view

	vga_timing_generator #(
		.H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
		.V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
	) timing_generator (
		.clk(clk), .rst_n(rst_n), .scan(scan)
	);

	tile_fetch #(.H_ACTIVE(H_ACTIVE), .TILE_SHIFT(TILE_SHIFT)) fetch (
		.clk(clk), .rst_n(rst_n), .scan(scan),
		.mem_addr(read_addr), .mem_data(read_data), .pix(pix)
	);

	frame_memory #(.DEPTH(DEPTH)) frame_mem (
		.clk(clk), .write(fb_write), .write_addr(fb_addr), .write_data(host_word),
		.read_addr(read_addr), .read_data(read_data)
	);

	pixel_output out_stage (
		.clk(clk), .rst_n(rst_n), .pix(pix),
		.vga_hs(vga_hs), .vga_vs(vga_vs), .vga_blank_n(vga_blank_n),
		.vga_r(vga_r), .vga_g(vga_g), .vga_b(vga_b)
	);

endmodule

// File: test/display_asserts.sv
`timescale 1ns/1ps

module display_asserts #(
	parameter int H_SYNC = display_pkg::DEF_H_SYNC
) (
	input logic                 clk,
	input logic                 rst_n,
	input logic                 hs,      // Registered active-low VGA hsync
	input logic                 blank_n,
	input display_pkg::colour_t r,
	input display_pkg::colour_t g,
	input display_pkg::colour_t b
);

	int failures = 0; // Failed assertion count

	// Black outside the active area
	blank_black: assert property (@(posedge clk) disable iff (!rst_n)
		!blank_n |-> (r == '0 && g == '0 && b == '0))
		else
		begin
			failures++;
			$error("colour driven while blanked");
		end

	// Sync pulse exactly H_SYNC clocks wide
	hs_width: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(hs) |-> !hs [*H_SYNC] ##1 hs)
		else
		begin
			failures++;
			$error("hsync pulse width wrong");
		end

	// Sync only inside blanking
	sync_blanked: assert property (@(posedge clk) disable iff (!rst_n)
		!hs |-> !blank_n)
		else
		begin
			failures++;
			$error("active pixel during hsync");
		end

endmodule

// File: test/display_tb.sv
`timescale 1ns/1ps

module display_tb;
	import display_pkg::*;

	localparam int CLK_PERIOD   = 20;
	localparam int H_TOTAL      = DEF_H_ACTIVE + DEF_H_FRONT + DEF_H_SYNC + DEF_H_BACK;
	localparam int V_TOTAL      = DEF_V_ACTIVE + DEF_V_FRONT + DEF_V_SYNC + DEF_V_BACK;
	localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL; // 288 clocks
	localparam int TILES_X      = DEF_H_ACTIVE >> DEF_TILE_SHIFT;
	localparam int TILES        = TILES_X * (DEF_V_ACTIVE >> DEF_TILE_SHIFT);

	logic        clk;
	logic        rst_n;
	logic        fb_write;
	logic [7:0]  fb_addr;
	logic [31:0] fb_data;
	logic        vga_hs;
	logic        vga_vs;
	logic        vga_blank_n;
	colour_t     vga_r;
	colour_t     vga_g;
	colour_t     vga_b;
	int          errors = 0;
	int          checks = 0;
	int          assert_fails;
	string       test_name;
	logic [31:0] model [TILES]; // Expected frame memory contents
	colour_t     shown [DEF_V_ACTIVE][DEF_H_ACTIVE][3]; // Last frame as r g b by position

	display_top dut (
		.clk(clk), .rst_n(rst_n), .fb_write(fb_write), .fb_addr(fb_addr), .fb_data(fb_data),
		.vga_hs(vga_hs), .vga_vs(vga_vs), .vga_blank_n(vga_blank_n),
		.vga_r(vga_r), .vga_g(vga_g), .vga_b(vga_b)
	);

	bind pixel_output display_asserts output_asserts (
		.clk(clk), .rst_n(rst_n), .hs(vga_hs), .blank_n(vga_blank_n),
		.r(vga_r), .g(vga_g), .b(vga_b)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Stops a hung run after twelve frame times
	initial
	begin
		#(12 * FRAME_CYCLES * CLK_PERIOD);
		$display("Timeout: the run did not finish within twelve frame times");
		$display("sim failed");
		$finish;
	end

	task automatic compare_colour(string what, colour_t expected, colour_t actual);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("[ERROR] %s %s: expected %h, actual %h", test_name, what, expected, actual);
		end
	endtask

	task automatic compare_level(string what, logic expected, logic actual);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("[ERROR] %s %s: expected %b, actual %b", test_name, what, expected, actual);
		end
	endtask

	task automatic compare_count(string what, int expected, int actual);
		checks++;
		if (actual != expected)
		begin
			errors++;
			$display("[ERROR] %s %s: expected %0d, actual %0d", test_name, what, expected, actual);
		end
	endtask

	task automatic host_write(logic [7:0] addr, logic [31:0] data);
		fb_write = 1'b1; // One-cycle strobe
		fb_addr  = addr;
		fb_data  = data;
		@(negedge clk);
		fb_write = 1'b0;
		if (addr < TILES)
			model[addr] = data; // Memory drops anything past the tile count
	endtask

	// Window runs from one vs fall to the next with position rebuilt from the syncs
	task automatic capture_frame();
		int   cycles;
		int   vs_low;
		int   hs_low;
		int   since_hs;
		int   px;
		int   ln;
		logic hs_prev;
		logic vs_prev;
		logic blank_prev;
		logic done;
		vs_prev = vga_vs;
		done    = 1'b0;
		while (!done)
		begin
			@(negedge clk);
			done    = !vga_vs && vs_prev; // vsync start
			vs_prev = vga_vs;
		end
		cycles     = 0;
		vs_low     = 1; // Fall sample is already low
		hs_low     = 0;
		since_hs   = -1; // No hs fall yet
		px         = 0;
		ln         = 0;
		hs_prev    = vga_hs;
		blank_prev = vga_blank_n;
		done       = 1'b0;
		while (!done)
		begin
			@(negedge clk);
			cycles++;
			done    = !vga_vs && vs_prev; // Next vsync closes the window
			vs_prev = vga_vs;
			if (!done)
			begin
				if (!vga_vs)
					vs_low++;
				if (!vga_hs)
					hs_low++;
				if (since_hs >= 0)
					since_hs++;
				if (!vga_hs && hs_prev)
				begin
					if (since_hs >= 0)
						compare_count("hs period", H_TOTAL, since_hs);
					since_hs = 0;
					if (px != 0)
					begin
						compare_count("active run", DEF_H_ACTIVE, px); // Line just ended
						ln++;
					end
					px = 0;
				end
				if (vga_hs && !hs_prev)
				begin
					compare_count("hs pulse", DEF_H_SYNC, hs_low);
					hs_low = 0;
				end
				if (vga_blank_n)
				begin
					if (!blank_prev && px != 0)
					begin
						errors++;
						$display("%s: active region split within one line", test_name);
					end
					if (ln < DEF_V_ACTIVE && px < DEF_H_ACTIVE)
						shown[ln][px] = '{vga_r, vga_g, vga_b};
					else
					begin
						errors++;
						$display("%s: active pixel outside the visible area", test_name);
					end
					px++;
				end
				else
				begin
					compare_colour("blanked red", '0, vga_r);
					compare_colour("blanked green", '0, vga_g);
					compare_colour("blanked blue", '0, vga_b);
				end
				hs_prev    = vga_hs;
				blank_prev = vga_blank_n;
			end
		end
		compare_count("frame cycles", FRAME_CYCLES, cycles);
		compare_count("vsync cycles", DEF_V_SYNC * H_TOTAL, vs_low); // V_SYNC whole lines
		compare_count("active lines", DEF_V_ACTIVE, ln);
	endtask

	// Every visible pixel against the word of its tile
	task automatic check_frame();
		int          tile;
		logic [31:0] word;
		for (int j = 0; j < DEF_V_ACTIVE; j++)
		begin
			for (int i = 0; i < DEF_H_ACTIVE; i++)
			begin
				tile = (j >> DEF_TILE_SHIFT) * TILES_X + (i >> DEF_TILE_SHIFT);
				word = model[tile];
				compare_colour($sformatf("red x%0d y%0d", i, j), word[15:8], shown[j][i][0]);
				compare_colour($sformatf("green x%0d y%0d", i, j), word[23:16], shown[j][i][1]);
				compare_colour($sformatf("blue x%0d y%0d", i, j), word[31:24], shown[j][i][2]);
			end
		end
	endtask

	task automatic reset_state();
		test_name = "reset_state";
		for (int c = 0; c < 5; c++)
		begin
			@(negedge clk);
			compare_level("hs", 1'b1, vga_hs);
			compare_level("vs", 1'b1, vga_vs);
			compare_level("blank_n", 1'b0, vga_blank_n);
			compare_colour("red", '0, vga_r);
			compare_colour("green", '0, vga_g);
			compare_colour("blue", '0, vga_b);
			if (c == 3)
				rst_n = 1'b1; // Last pass checks the first cycle out of reset
		end
	endtask

	task automatic raster_timing();
		test_name = "raster_timing";
		capture_frame(); // Memory still unwritten so timing only
	endtask

	task automatic tile_mapping();
		test_name = "tile_mapping";
		for (int t = 0; t < TILES; t++)
			host_write(8'(t), {8'h10 + 8'(t), 8'h40 + 8'(t), 8'h80 + 8'(t), 8'hf0 + 8'(t)});
		capture_frame();
		check_frame();
	endtask

	task automatic random_byte_order();
		test_name = "random_byte_order";
		for (int t = 0; t < TILES; t++)
			host_write(8'(t), $urandom());
		capture_frame();
		check_frame(); // Alpha byte would show up as a mismatch
	endtask

	// Starts right at a vs fall so the writes land in vertical blanking
	task automatic live_update();
		test_name = "live_update";
		host_write(8'd5, 32'h5a3c_961e);
		host_write(8'(TILES), 32'hffff_ffff); // First address past the end
		host_write(8'hff, 32'h1234_5678);
		capture_frame();
		check_frame();
	endtask

	initial
	begin
		rst_n    = 1'b0;
		fb_write = 1'b0;
		fb_addr  = '0;
		fb_data  = '0;
		void'($urandom(32'hf8bb_9224));
		reset_state();
		raster_timing();
		tile_mapping();
		random_byte_order();
		live_update();
		assert_fails = dut.out_stage.output_asserts.failures;
		$display("Done: %0d checks, %0d errors, %0d assertion failures",
			checks, errors, assert_fails);
		if (errors == 0 && assert_fails == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

// File: verilog.f
verilog/display_pkg.sv
verilog/scan_if.sv
verilog/pixel_if.sv
verilog/vga_timing_generator.sv
verilog/frame_memory.sv
verilog/tile_fetch.sv
verilog/pixel_output.sv
verilog/display_top.sv
test/display_asserts.sv
test/display_tb.sv

// File: Bender.yml
package:
  name: tiled_display

sources:
  - verilog/display_pkg.sv
  - verilog/scan_if.sv
  - verilog/pixel_if.sv
  - verilog/vga_timing_generator.sv
  - verilog/frame_memory.sv
  - verilog/tile_fetch.sv
  - verilog/pixel_output.sv
  - verilog/display_top.sv
  - target: test
    files:
      - test/display_asserts.sv
      - test/display_tb.sv
